// File: Makefile
# Verilator build and run for the L2 directory testbench

SIM      ?= verilator
FLAGS    ?= --timing --assert
TOP      ?= l2CacheTb
FILELIST ?= verilog.f
OBJDIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run exits non-zero on any failure
sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: common/busPkg.sv
// Command encodings for the L1 channel, the shared bus
// and the snoop responses
package busPkg;

  // L1 requests; an instruction fetch is sent as a data read
  typedef enum logic {
    L1_READ,
    L1_WRITE
  } l1OpT;

  // Shared-bus operations
  // Snooped requests only ever carry READ, RFO or INVALIDATE
  typedef enum logic [1:0] {
    BUS_READ,
    BUS_RFO,
    BUS_INVALIDATE,
    BUS_WRITEBACK
  } busOpT;

  // Snoop answer, also returned to us with our own bus reads
  typedef enum logic [1:0] {
    SNOOP_MISS = 2'b00,
    SNOOP_HIT  = 2'b01,
    SNOOP_HITM = 2'b10
  } snoopResultT;

endpackage

// File: common/cachePkg.sv
// Cache geometry types: address fields, way numbers, LRU ages,
// MESI line state and statistics counters
package cachePkg;

`include "l2CacheDefs_defs.svh"

  // Full byte address as seen on both inbound channels
  typedef logic [`ADDR_BITS-1:0] addrT;

  // Upper address bits stored per line
  typedef logic [`TAG_BITS-1:0] tagT;

  // Set select
  typedef logic [`INDEX_BITS-1:0] indexT;

  // One of four ways
  typedef logic [$clog2(`WAYS)-1:0] wayT;

  // Age 0 is the most recently used way, age WAYS-1 the oldest
  typedef logic [$clog2(`WAYS)-1:0] lruAgeT;

  // Line coherence state
  typedef enum logic [1:0] {
    MESI_M,
    MESI_E,
    MESI_S,
    MESI_I
  } mesiT;

  // Hit, miss, read and write statistics
  typedef logic [31:0] counterT;

endpackage

// File: common/l2CacheDefs_defs.svh
// Address split, cache geometry and flow-control sizes
// for the snooping L2 directory
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// Address split: tag | index | byte select
`define ADDR_BITS     32
`define OFFSET_BITS   6
`define INDEX_BITS    4
`define TAG_BITS      22

// Four ways per set
`define WAYS          4

// Inbound channel sizing
`define REQ_DEPTH     2
`define SNOOP_CREDITS 1

`endif

// File: common/lookupIf.sv
// Lookup and update channel between the coherence controller
// and the tag array
`timescale 1ns/1ps

interface lookupIf;
  import cachePkg::*;

  // Lookup request, results come back registered one cycle later
  logic  lookupValid;
  tagT   lookupTag;
  indexT lookupIndex;
  logic  hit;
  wayT   hitWay;
  mesiT  hitState;
  wayT   victimWay;
  mesiT  victimState;
  tagT   victimTag;

  // Line update, always applied to the set last looked up
  logic  updateValid;
  wayT   updateWay;
  tagT   updateTag;
  mesiT  updateState;
  logic  updateTouch;

  modport ctrl (
    output lookupValid, lookupTag, lookupIndex,
    output updateValid, updateWay, updateTag, updateState, updateTouch,
    input  hit, hitWay, hitState, victimWay, victimState, victimTag
  );

  modport array (
    input  lookupValid, lookupTag, lookupIndex,
    input  updateValid, updateWay, updateTag, updateState, updateTouch,
    output hit, hitWay, hitState, victimWay, victimState, victimTag
  );
endinterface

// File: dv/l2CacheTb.sv
// Testbench for the L2 directory: clock, reset, credit-based stimulus,
// random-delay shared-bus responder and a reference MESI/LRU model
`timescale 1ns/1ps
`include "l2CacheDefs_defs.svh"

module l2CacheTb;
  import cachePkg::*;
  import busPkg::*;

  localparam int TIMEOUT = 200;
  localparam int NUM_SETS = 1 << `INDEX_BITS;

  logic clk;
  logic arstN;
  logic l1ReqValid, l1Credit, l1RespValid, l1RespHit;
  l1OpT l1ReqOp;
  addrT l1ReqAddr, snoopAddr, busAddr;
  logic snoopValid, snoopCredit, snoopRespValid, busReqValid, busRespValid;
  busOpT snoopOp, busOp;
  snoopResultT snoopResult, busSnoopResult;
  counterT hitCount, missCount, readCount, writeCount;

  // Monitor records, stamped with the cycle number
  int cycle = 0;
  int l1Sent = 0;
  int l1CreditCount = 0;
  int snoopsSent = 0;
  int snoopCreditCount = 0;
  int snoopRespCycle, snoopCreditCycle;
  int busWait = 0;
  integer seed = 32'hce9d;
  logic l1RespQ[$];
  int l1RespCycleQ[$];
  int acceptQ[$];
  snoopResultT snoopResQ[$];
  busOpT busOpQ[$];
  addrT busAddrQ[$];
  snoopResultT busResQ[$];

  // Reference model of the array
  tagT mTag[`WAYS][NUM_SETS];
  mesiT mState[`WAYS][NUM_SETS];
  lruAgeT mAge[`WAYS][NUM_SETS];
  counterT mHits = 0;
  counterT mMisses = 0;
  counterT mReads = 0;
  counterT mWrites = 0;

  l2Cache i_dut (.*);

  bind l2Cache l2CacheProperties i_props (
    .clk, .arstN, .l1Credit, .l1RespValid, .snoopCredit, .snoopRespValid,
    .snoopResult, .busReqValid, .busOp, .busAddr, .busRespValid
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ************************************************************************
  // Failure reporting and model helpers
  // ************************************************************************
  task automatic abortRun();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic expectEqual(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      abortRun();
    end
  endtask

  function automatic indexT indexOf(addrT a);
    return a[`OFFSET_BITS +: `INDEX_BITS];
  endfunction

  function automatic tagT tagOf(addrT a);
    return a[`ADDR_BITS-1 -: `TAG_BITS];
  endfunction

  // Way holding a valid copy of the line, -1 when absent
  function automatic int findWay(addrT a);
    int way;
    way = -1;
    for (int w = `WAYS - 1; w >= 0; w--) begin
      if (mState[w][indexOf(a)] != MESI_I && mTag[w][indexOf(a)] == tagOf(a)) way = w;
    end
    return way;
  endfunction

  // Lowest free way, else the one of age 3
  function automatic int pickVictim(indexT s);
    int way;
    way = -1;
    for (int w = `WAYS - 1; w >= 0; w--) begin
      if (mState[w][s] == MESI_I) way = w;
    end
    for (int w = 0; w < `WAYS; w++) begin
      if (way < 0 && mAge[w][s] == lruAgeT'(`WAYS - 1)) way = w;
    end
    return way;
  endfunction

  task automatic touchWay(indexT s, int way);
    lruAgeT old;
    old = mAge[way][s];
    for (int w = 0; w < `WAYS; w++) begin
      if (w == way) mAge[w][s] = '0;
      else if (mAge[w][s] < old) mAge[w][s] = mAge[w][s] + 1'b1;
    end
  endtask

  // Next logged bus operation must match
  task automatic expectBusOp(busOpT op, addrT a, output snoopResultT res);
    assert (busOpQ.size() > 0) else begin
      $display("expected bus operation %s was never issued", op.name());
      abortRun();
    end
    expectEqual("busOp", busOpQ.pop_front(), op);
    expectEqual("busAddr", busAddrQ.pop_front(), a);
    res = busResQ.pop_front();
  endtask

  // ************************************************************************
  // Monitors and shared-bus responder
  // ************************************************************************
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (l1RespValid) begin
      l1RespQ.push_back(l1RespHit);
      l1RespCycleQ.push_back(cycle);
    end
    if (l1Credit) l1CreditCount <= l1CreditCount + 1;
    if (snoopRespValid) begin
      snoopResQ.push_back(snoopResult);
      snoopRespCycle <= cycle;
    end
    if (snoopCredit) begin
      snoopCreditCount <= snoopCreditCount + 1;
      snoopCreditCycle <= cycle;
    end
  end

  // Answers after 1 to 4 cycles with a random snoop result
  always @(posedge clk) begin
    snoopResultT res;
    busRespValid <= 1'b0;
    if (busReqValid && !busRespValid) begin
      if (busWait == 0) begin
        res = snoopResultT'($unsigned($random(seed)) % 3);
        busRespValid   <= 1'b1;
        busSnoopResult <= res;
        busOpQ.push_back(busOp);
        busAddrQ.push_back(busAddr);
        busResQ.push_back(res);
        busWait <= $unsigned($random(seed)) % 4;
      end else begin
        busWait <= busWait - 1;
      end
    end
  end

  // ************************************************************************
  // Stimulus tasks
  // ************************************************************************
  task automatic sendL1(l1OpT op, addrT a);
    assert (`REQ_DEPTH - l1Sent + l1CreditCount > 0) else begin
      $display("L1 request attempted without a credit");
      abortRun();
    end
    @(posedge clk);
    l1ReqValid <= 1'b1;
    l1ReqOp    <= op;
    l1ReqAddr  <= a;
    @(posedge clk);
    l1ReqValid <= 1'b0;
    l1Sent++;
    acceptQ.push_back(cycle);
  endtask

  task automatic waitL1Resp(output logic hit, output int latency);
    int n;
    n = 0;
    while (l1RespQ.size() == 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("timed out waiting for an L1 response");
        abortRun();
      end
    end
    hit = l1RespQ.pop_front();
    latency = l1RespCycleQ.pop_front() - acceptQ.pop_front();
  endtask

  // One L1 request with the controller idle, checked against the model
  task automatic runL1(l1OpT op, addrT a);
    indexT s;
    int way, latency;
    logic gotHit;
    snoopResultT res;
    s = indexOf(a);
    way = findWay(a);
    sendL1(op, a);
    waitL1Resp(gotHit, latency);
    expectEqual("l1RespHit", gotHit, way >= 0);
    if (way >= 0) begin
      // Write to a shared line upgrades through an invalidate
      if (op == L1_WRITE && mState[way][s] == MESI_S) begin
        expectBusOp(BUS_INVALIDATE, {tagOf(a), s, {`OFFSET_BITS{1'b0}}}, res);
      end else begin
        expectEqual("l1RespValid latency", latency, 2);
      end
      if (op == L1_WRITE) mState[way][s] = MESI_M;
      mHits++;
    end else begin
      way = pickVictim(s);
      if (mState[way][s] == MESI_M) begin
        expectBusOp(BUS_WRITEBACK, {mTag[way][s], s, {`OFFSET_BITS{1'b0}}}, res);
      end
      expectBusOp((op == L1_WRITE) ? BUS_RFO : BUS_READ, {tagOf(a), s, {`OFFSET_BITS{1'b0}}}, res);
      mTag[way][s]   = tagOf(a);
      mState[way][s] = (op == L1_WRITE) ? MESI_M : (res == SNOOP_MISS) ? MESI_E : MESI_S;
      mMisses++;
    end
    touchWay(s, way);
    if (op == L1_WRITE) mWrites++;
    else mReads++;
    assert (busOpQ.size() == 0) else begin
      $display("unexpected extra bus operation %s", busOpQ[0].name());
      abortRun();
    end
  endtask

  task automatic runSnoop(busOpT op, addrT a);
    int way, n;
    snoopResultT expRes, res;
    way = findWay(a);
    expRes = (way < 0) ? SNOOP_MISS :
             (mState[way][indexOf(a)] == MESI_M) ? SNOOP_HITM : SNOOP_HIT;
    assert (`SNOOP_CREDITS - snoopsSent + snoopCreditCount > 0) else begin
      $display("snoop attempted without a credit");
      abortRun();
    end
    @(posedge clk);
    snoopValid <= 1'b1;
    snoopOp    <= op;
    snoopAddr  <= a;
    @(posedge clk);
    snoopValid <= 1'b0;
    snoopsSent++;
    acceptQ.push_back(cycle);
    n = 0;
    // Credit marks the end, after any writeback
    while (snoopCreditCount != snoopsSent) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("timed out waiting for the snoop credit");
        abortRun();
      end
    end
    expectEqual("snoopRespValid count", snoopResQ.size(), 1);
    expectEqual("snoopResult", snoopResQ.pop_front(), expRes);
    expectEqual("snoopRespValid latency", snoopRespCycle - acceptQ.pop_front(), 2);
    if (expRes == SNOOP_HITM) begin
      expectBusOp(BUS_WRITEBACK, {tagOf(a), indexOf(a), {`OFFSET_BITS{1'b0}}}, res);
    end else begin
      expectEqual("snoopCredit cycle", snoopCreditCycle, snoopRespCycle);
    end
    if (way >= 0) mState[way][indexOf(a)] = (op == BUS_READ) ? MESI_S : MESI_I;
  endtask

  // ************************************************************************
  // Test sequence
  // ************************************************************************
  initial begin
    logic hit;
    int latency;
    int way;
    arstN          = 1'b0;
    l1ReqValid     = 1'b0;
    l1ReqOp        = L1_READ;
    l1ReqAddr      = '0;
    snoopValid     = 1'b0;
    snoopOp        = BUS_READ;
    snoopAddr      = '0;
    busRespValid   = 1'b0;
    busSnoopResult = SNOOP_MISS;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < `WAYS; w++) begin
        mState[w][s] = MESI_I;
        mAge[w][s]   = lruAgeT'(w);
      end
    end
    repeat (3) @(posedge clk);
    arstN <= 1'b1;

    // Quiet outputs and zero counters out of reset
    repeat (4) begin
      @(posedge clk);
      expectEqual("valid and credit outputs",
                  {l1Credit, l1RespValid, snoopCredit, snoopRespValid, busReqValid}, 0);
    end
    expectEqual("hitCount", hitCount, 0);
    expectEqual("missCount", missCount, 0);
    expectEqual("readCount", readCount, 0);
    expectEqual("writeCount", writeCount, 0);

    // Read miss, read hit, then write with the invalidate decided by the fill
    runL1(L1_READ, 32'h0000_1040);
    runL1(L1_READ, 32'h0000_1040);
    runL1(L1_WRITE, 32'h0000_1040);

    // RFO fill, then two snoop reads: HITM with writeback, then HIT
    runL1(L1_WRITE, 32'h0002_0080);
    runSnoop(BUS_READ, 32'h0002_0080);
    runSnoop(BUS_READ, 32'h0002_0080);

    // Invalidate and RFO snoops, the dropped line misses afterwards
    runSnoop(BUS_INVALIDATE, 32'h0000_1040);
    runSnoop(BUS_RFO, 32'h0003_00c0);
    runL1(L1_READ, 32'h0000_1040);

    // Five tags in set 5, the dirty LRU way is written back
    runL1(L1_WRITE, {tagT'(8), indexT'(5), {`OFFSET_BITS{1'b0}}});
    for (int t = 9; t <= 12; t++) begin
      runL1(L1_READ, {tagT'(t), indexT'(5), {`OFFSET_BITS{1'b0}}});
    end
    runL1(L1_READ, {tagT'(8), indexT'(5), {`OFFSET_BITS{1'b0}}});

    // Two requests in flight on two credits, both resident
    sendL1(L1_READ, {tagT'(11), indexT'(5), {`OFFSET_BITS{1'b0}}});
    sendL1(L1_READ, {tagT'(12), indexT'(5), {`OFFSET_BITS{1'b0}}});
    for (int t = 11; t <= 12; t++) begin
      way = findWay({tagT'(t), indexT'(5), {`OFFSET_BITS{1'b0}}});
      waitL1Resp(hit, latency);
      expectEqual("l1RespHit", hit, way >= 0);
      touchWay(5, way);
      mReads++;
      mHits++;
    end

    // Drain, then totals against the model
    repeat (5) @(posedge clk);
    expectEqual("hitCount + missCount", hitCount + missCount, readCount + writeCount);
    expectEqual("hitCount", hitCount, mHits);
    expectEqual("missCount", missCount, mMisses);
    expectEqual("readCount", readCount, mReads);
    expectEqual("writeCount", writeCount, mWrites);
    expectEqual("l1Credit total", l1CreditCount, l1Sent);
    expectEqual("snoopCredit total", snoopCreditCount, snoopsSent);
    assert (l1RespQ.size() == 0 && snoopResQ.size() == 0 && busOpQ.size() == 0) else begin
      $display("responses or bus operations left over at the end of the run");
      abortRun();
    end
    $display("all tests passed");
    $finish;
  end
endmodule

// File: dv/l2Cache_properties.sv
// Port protocol checks for the L2 directory
// Credit and response pairing, snoop credit timing, bus request stability
`timescale 1ns/1ps

module l2CacheProperties (
  input logic                clk,
  input logic                arstN,
  input logic                l1Credit,
  input logic                l1RespValid,
  input logic                snoopCredit,
  input logic                snoopRespValid,
  input busPkg::snoopResultT snoopResult,
  input logic                busReqValid,
  input busPkg::busOpT       busOp,
  input cachePkg::addrT      busAddr,
  input logic                busRespValid
);
  import busPkg::*;

  // ************************************************************************
  // Inbound channels
  // ************************************************************************
  // An L1 request retires with its response and its credit together
  l1RespWithCredit: assert property (@(posedge clk) disable iff (!arstN)
    l1RespValid == l1Credit)
    else $error("L1 response and L1 credit not in the same cycle");

  // Snoop without HITM hands the credit back with the answer
  snoopCleanCredit: assert property (@(posedge clk) disable iff (!arstN)
    snoopRespValid && (snoopResult != SNOOP_HITM) |-> snoopCredit)
    else $error("snoop credit missing on a clean snoop answer");

  // HITM holds the credit and starts the writeback next cycle
  snoopDirtyWriteback: assert property (@(posedge clk) disable iff (!arstN)
    snoopRespValid && (snoopResult == SNOOP_HITM) |->
      !snoopCredit ##1 (busReqValid && busOp == BUS_WRITEBACK))
    else $error("HITM snoop not followed by a writeback");

  // Quiet outputs while reset is held
  resetQuiet: assert property (@(posedge clk)
    !arstN |-> !(l1Credit || l1RespValid || snoopCredit || snoopRespValid || busReqValid))
    else $error("valid or credit output active during reset");

  // ************************************************************************
  // Shared bus
  // ************************************************************************
  // Request stays put until the response arrives
  busReqStable: assert property (@(posedge clk) disable iff (!arstN)
    busReqValid && !busRespValid |=>
      busReqValid && $stable(busOp) && $stable(busAddr))
    else $error("bus request changed while waiting for its response");

  busReqKnown: assert property (@(posedge clk) disable iff (!arstN)
    busReqValid |-> !$isunknown({busOp, busAddr}))
    else $error("bus request carries unknown bits");

  // No L1 retirement while a bus request is still open
  retireAfterBus: assert property (@(posedge clk) disable iff (!arstN)
    l1RespValid |-> !busReqValid)
    else $error("L1 response while a bus request is outstanding");

endmodule

// File: l2cache/coherenceCtrl.sv
// L1 request queue, snoop holding register and MESI state machine
// Shared-bus sequencing, credit return and statistics counters
`timescale 1ns/1ps
`include "l2CacheDefs_defs.svh"

module coherenceCtrl (
  input  logic                clk,
  input  logic                arstN,
  input  logic                l1ReqValid,
  input  busPkg::l1OpT        l1ReqOp,
  input  cachePkg::addrT      l1ReqAddr,
  output logic                l1Credit,
  output logic                l1RespValid,
  output logic                l1RespHit,
  input  logic                snoopValid,
  input  busPkg::busOpT       snoopOp,
  input  cachePkg::addrT      snoopAddr,
  output logic                snoopCredit,
  output logic                snoopRespValid,
  output busPkg::snoopResultT snoopResult,
  output logic                busReqValid,
  output busPkg::busOpT       busOp,
  output cachePkg::addrT      busAddr,
  input  logic                busRespValid,
  input  busPkg::snoopResultT busSnoopResult,
  output cachePkg::counterT   hitCount,
  output cachePkg::counterT   missCount,
  output cachePkg::counterT   readCount,
  output cachePkg::counterT   writeCount,
  lookupIf.ctrl               lookup
);
  import cachePkg::*;
  import busPkg::*;

  localparam int PTR_BITS = $clog2(`REQ_DEPTH);
  localparam int CNT_BITS = $clog2(`REQ_DEPTH + 1);

  typedef enum logic [2:0] {IDLE, LOOKUP, DECIDE, WRITEBACK, BUSREQ, FINISH} stateT;

  stateT state, stateNext;

  // L1 request FIFO
  l1OpT  qOp   [`REQ_DEPTH];
  addrT  qAddr [`REQ_DEPTH];
  logic [PTR_BITS-1:0] wrPtr, rdPtr;
  logic [CNT_BITS-1:0] qCount;

  // Snoop holding register
  logic  snoopPending;
  busOpT snoopOpReg;
  addrT  snoopAddrReg;

  // Operation in progress
  logic  curIsSnoop, curHitReg;
  l1OpT  curL1Op;
  busOpT curSnoopOp, busOpReg;
  addrT  curAddr;
  tagT   curTag, wbTagReg;
  indexT curIndex;
  wayT   wayReg;
  snoopResultT busResReg;

  logic  snoopAvail, l1Avail, takeSnoop, takeL1, needInval, l1Retire;

  assign curTag   = curAddr[`ADDR_BITS-1 -: `TAG_BITS];
  assign curIndex = curAddr[`OFFSET_BITS +: `INDEX_BITS];

  // ************************************************************************
  // Intake, snoops win over queued L1 requests
  // ************************************************************************
  assign snoopAvail = snoopPending || snoopValid;
  assign l1Avail    = (qCount != '0) || l1ReqValid;
  assign takeSnoop  = (state == IDLE) && snoopAvail;
  assign takeL1     = (state == IDLE) && !snoopAvail && l1Avail;

  always_ff @(posedge clk) begin
    if (l1ReqValid) begin
      qOp[wrPtr]   <= l1ReqOp;
      qAddr[wrPtr] <= l1ReqAddr;
    end
    if (snoopValid) begin
      snoopOpReg   <= snoopOp;
      snoopAddrReg <= snoopAddr;
    end
    // Empty queue or idle snoop register is bypassed
    if (takeSnoop) begin
      curSnoopOp <= snoopPending ? snoopOpReg : snoopOp;
      curAddr    <= snoopPending ? snoopAddrReg : snoopAddr;
    end else if (takeL1) begin
      curL1Op <= (qCount != '0) ? qOp[rdPtr] : l1ReqOp;
      curAddr <= (qCount != '0) ? qAddr[rdPtr] : l1ReqAddr;
    end
    // Decision for the remaining steps
    if (state == DECIDE) begin
      curHitReg <= lookup.hit;
      wayReg    <= lookup.hit ? lookup.hitWay : lookup.victimWay;
      wbTagReg  <= curIsSnoop ? curTag : lookup.victimTag;
      busOpReg  <= lookup.hit ? BUS_INVALIDATE :
                   (curL1Op == L1_WRITE) ? BUS_RFO : BUS_READ;
    end
    if ((state == BUSREQ) && busRespValid) begin
      busResReg <= busSnoopResult;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state        <= IDLE;
      curIsSnoop   <= 1'b0;
      snoopPending <= 1'b0;
      wrPtr        <= '0;
      rdPtr        <= '0;
      qCount       <= '0;
      hitCount     <= '0;
      missCount    <= '0;
      readCount    <= '0;
      writeCount   <= '0;
    end else begin
      state        <= stateNext;
      snoopPending <= takeSnoop ? (snoopPending && snoopValid) : snoopAvail;
      if (takeSnoop || takeL1) begin
        curIsSnoop <= takeSnoop;
      end
      if (l1ReqValid) begin
        wrPtr <= (wrPtr == PTR_BITS'(`REQ_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (takeL1) begin
        rdPtr <= (rdPtr == PTR_BITS'(`REQ_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      if (l1ReqValid && !takeL1) begin
        qCount <= qCount + 1'b1;
      end else if (!l1ReqValid && takeL1) begin
        qCount <= qCount - 1'b1;
      end
      // Statistics at retirement
      if (l1Retire) begin
        if (curL1Op == L1_WRITE) writeCount <= writeCount + 1'b1;
        else readCount <= readCount + 1'b1;
        if (l1RespHit) hitCount <= hitCount + 1'b1;
        else missCount <= missCount + 1'b1;
      end
    end
  end

  // ************************************************************************
  // MESI state machine
  // ************************************************************************
  // Write to a shared line has to invalidate the other copies first
  assign needInval = (curL1Op == L1_WRITE) && (lookup.hitState == MESI_S);

  always_comb begin
    stateNext = state;
    case (state)
      IDLE:      if (takeSnoop || takeL1) stateNext = LOOKUP;
      LOOKUP:    stateNext = DECIDE;
      DECIDE: begin
        if (curIsSnoop) begin
          stateNext = (lookup.hit && lookup.hitState == MESI_M) ? WRITEBACK : IDLE;
        end else if (lookup.hit) begin
          stateNext = needInval ? BUSREQ : IDLE;
        end else begin
          // Dirty victim goes out before the fill
          stateNext = (lookup.victimState == MESI_M) ? WRITEBACK : BUSREQ;
        end
      end
      WRITEBACK: if (busRespValid) stateNext = curIsSnoop ? FINISH : BUSREQ;
      BUSREQ:    if (busRespValid) stateNext = FINISH;
      default:   stateNext = IDLE;
    endcase
  end

  // Lookup and update drive
  assign lookup.lookupValid = (state == LOOKUP);
  assign lookup.lookupTag   = curTag;
  assign lookup.lookupIndex = curIndex;
  assign lookup.updateTag   = curTag;

  always_comb begin
    lookup.updateValid = 1'b0;
    lookup.updateTouch = 1'b0;
    lookup.updateWay   = lookup.hitWay;
    lookup.updateState = lookup.hitState;
    if (state == DECIDE && lookup.hit) begin
      if (curIsSnoop) begin
        // Snoop read keeps a shared copy, RFO and invalidate drop it
        lookup.updateValid = 1'b1;
        lookup.updateState = (curSnoopOp == BUS_READ) ? MESI_S : MESI_I;
      end else if (!needInval) begin
        lookup.updateValid = 1'b1;
        lookup.updateTouch = 1'b1;
        if (curL1Op == L1_WRITE) lookup.updateState = MESI_M;
      end
    end else if (state == FINISH && !curIsSnoop) begin
      // Fill, or upgrade after the invalidate
      lookup.updateValid = 1'b1;
      lookup.updateTouch = 1'b1;
      lookup.updateWay   = wayReg;
      lookup.updateState = (curL1Op == L1_WRITE) ? MESI_M :
                           (busResReg == SNOOP_MISS) ? MESI_E : MESI_S;
    end
  end

  // ************************************************************************
  // Responses, credits and shared bus
  // ************************************************************************
  assign l1Retire    = !curIsSnoop && ((state == DECIDE && lookup.hit && !needInval) ||
                                       state == FINISH);
  assign l1RespValid = l1Retire;
  assign l1Credit    = l1Retire;
  assign l1RespHit   = (state == DECIDE) ? lookup.hit : curHitReg;

  assign snoopRespValid = (state == DECIDE) && curIsSnoop;
  assign snoopResult    = !lookup.hit ? SNOOP_MISS :
                          (lookup.hitState == MESI_M) ? SNOOP_HITM : SNOOP_HIT;
  // HITM returns the credit only once the writeback is done
  assign snoopCredit    = curIsSnoop && ((state == FINISH) ||
                          (state == DECIDE && snoopResult != SNOOP_HITM));

  // Held steady by the state registers until busRespValid
  assign busReqValid = (state == WRITEBACK) || (state == BUSREQ);
  assign busOp       = (state == WRITEBACK) ? BUS_WRITEBACK : busOpReg;
  assign busAddr     = {(state == WRITEBACK) ? wbTagReg : curTag, curIndex,
                        {`OFFSET_BITS{1'b0}}};
endmodule

// File: l2cache/tagArray.sv
// Tag, MESI and LRU storage for all sets and ways
// Per-way comparators, hit encoder, victim choice and line update
`timescale 1ns/1ps
`include "l2CacheDefs_defs.svh"

module tagArray (
  input logic    clk,
  input logic    arstN,
  lookupIf.array lookup
);
  import cachePkg::*;

  localparam int NUM_SETS = 1 << `INDEX_BITS;

  // ************************************************************************
  // Storage
  // ************************************************************************
  tagT    tagMem   [`WAYS][NUM_SETS];
  mesiT   stateMem [`WAYS][NUM_SETS];
  lruAgeT ageMem   [`WAYS][NUM_SETS];

  // Set of the last lookup, target of every update
  indexT  lastIndex;

  logic [`WAYS-1:0] wayMatch;
  logic [`WAYS-1:0] wayInvalid;
  logic   hitNext;
  wayT    hitWayNext;
  wayT    victimWayNext;
  lruAgeT touchedAge;

  // ************************************************************************
  // Comparators, one per way
  // ************************************************************************
  for (genvar w = 0; w < `WAYS; w++) begin : g_way
    // Invalid lines never hit, whatever their stale tag
    assign wayInvalid[w] = (stateMem[w][lookup.lookupIndex] == MESI_I);
    assign wayMatch[w]   = (tagMem[w][lookup.lookupIndex] == lookup.lookupTag) &&
                           !wayInvalid[w];
  end

  // Priority encoders for the hit way and the victim way
  always_comb begin
    hitNext       = |wayMatch;
    hitWayNext    = '0;
    victimWayNext = '0;
    // Lowest matching way
    for (int w = `WAYS - 1; w >= 0; w--) begin
      if (wayMatch[w]) begin
        hitWayNext = wayT'(w);
      end
    end
    // Lowest invalid way first, otherwise the oldest one
    if (|wayInvalid) begin
      for (int w = `WAYS - 1; w >= 0; w--) begin
        if (wayInvalid[w]) begin
          victimWayNext = wayT'(w);
        end
      end
    end else begin
      for (int w = 0; w < `WAYS; w++) begin
        if (ageMem[w][lookup.lookupIndex] == lruAgeT'(`WAYS - 1)) begin
          victimWayNext = wayT'(w);
        end
      end
    end
  end

  // Results are held until the next lookup
  always_ff @(posedge clk) begin
    if (lookup.lookupValid) begin
      lastIndex          <= lookup.lookupIndex;
      lookup.hit         <= hitNext;
      lookup.hitWay      <= hitWayNext;
      lookup.hitState    <= stateMem[hitWayNext][lookup.lookupIndex];
      lookup.victimWay   <= victimWayNext;
      lookup.victimState <= stateMem[victimWayNext][lookup.lookupIndex];
      lookup.victimTag   <= tagMem[victimWayNext][lookup.lookupIndex];
    end
  end

  // ************************************************************************
  // Line update and LRU aging
  // ************************************************************************
  assign touchedAge = ageMem[lookup.updateWay][lastIndex];

  always_ff @(posedge clk) begin
    if (lookup.updateValid) begin
      tagMem[lookup.updateWay][lastIndex] <= lookup.updateTag;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // All lines invalid, way i starts at age i
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < `WAYS; w++) begin
          stateMem[w][s] <= MESI_I;
          ageMem[w][s]   <= lruAgeT'(w);
        end
      end
    end else if (lookup.updateValid) begin
      stateMem[lookup.updateWay][lastIndex] <= lookup.updateState;
      if (lookup.updateTouch) begin
        // Touched way becomes newest, younger ways age by one
        for (int w = 0; w < `WAYS; w++) begin
          if (wayT'(w) == lookup.updateWay) begin
            ageMem[w][lastIndex] <= '0;
          end else if (ageMem[w][lastIndex] < touchedAge) begin
            ageMem[w][lastIndex] <= ageMem[w][lastIndex] + 1'b1;
          end
        end
      end
    end
  end
endmodule

// File: verilog.f
+incdir+common
common/cachePkg.sv
common/busPkg.sv
common/lookupIf.sv
l2cache/tagArray.sv
l2cache/coherenceCtrl.sv
verilog/l2Cache.sv
dv/l2Cache_properties.sv
dv/l2CacheTb.sv

// File: verilog/l2Cache.sv
// L2 directory top level
// Coherence controller and tag array joined by the lookup interface
`timescale 1ns/1ps

module l2Cache (
  input  logic                clk,
  input  logic                arstN,
  // L1 request channel, credit based
  input  logic                l1ReqValid,
  input  busPkg::l1OpT        l1ReqOp,
  input  cachePkg::addrT      l1ReqAddr,
  output logic                l1Credit,
  output logic                l1RespValid,
  output logic                l1RespHit,
  // Snoop channel, credit based
  input  logic                snoopValid,
  input  busPkg::busOpT       snoopOp,
  input  cachePkg::addrT      snoopAddr,
  output logic                snoopCredit,
  output logic                snoopRespValid,
  output busPkg::snoopResultT snoopResult,
  // Shared bus, one request outstanding
  output logic                busReqValid,
  output busPkg::busOpT       busOp,
  output cachePkg::addrT      busAddr,
  input  logic                busRespValid,
  input  busPkg::snoopResultT busSnoopResult,
  // Statistics
  output cachePkg::counterT   hitCount,
  output cachePkg::counterT   missCount,
  output cachePkg::counterT   readCount,
  output cachePkg::counterT   writeCount
);

  lookupIf lookupBus ();

  // Command handling and bus sequencing
  coherenceCtrl i_ctrl (
    .clk, .arstN,
    .l1ReqValid, .l1ReqOp, .l1ReqAddr, .l1Credit, .l1RespValid, .l1RespHit,
    .snoopValid, .snoopOp, .snoopAddr, .snoopCredit, .snoopRespValid, .snoopResult,
    .busReqValid, .busOp, .busAddr, .busRespValid, .busSnoopResult,
    .hitCount, .missCount, .readCount, .writeCount,
    .lookup (lookupBus.ctrl)
  );

  // Tags, MESI state and LRU ages
  tagArray i_tags (
    .clk,
    .arstN,
    .lookup (lookupBus.array)
  );
endmodule
